//--- sources.f
verilog/commit_pkg.sv
verilog/rec_fifo.sv
verilog/rr_arbiter.sv
verilog/perf_counters.sv
verilog/trace_ctrl.sv
verilog/commit_trace_top.sv
tb/commit_trace_assert.sv
tb/tb_commit_trace.sv

//--- run.sh
#!/bin/sh
# Build and run the commit trace testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f sources.f --top-module tb_commit_trace -Mdir obj_dir

# Raise the runtime error limit so the testbench reaches its own report
out=$(./obj_dir/Vtb_commit_trace +verilator+error+limit+1000 2>&1) || true
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -q "TEST OK"

//--- tb/tb_commit_trace.sv
// Commit trace testbench
`default_nettype none

module tb_commit_trace;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NP          = commit_pkg::NR_COMMIT_PORTS;
  // Commits over all tests, bounds the watchdog
  localparam int NUM_COMMITS = 20 + 60 + 30 + 24;
  localparam int WD_CYCLES   = NUM_COMMITS * 40 + 500;

  logic                                clk_i;
  logic                                rst_ni;
  commit_pkg::commit_entry_t [NP-1:0]  commit_i;
  logic [NP-1:0]                       commit_ack_i;
  logic                                commit_stall_o;
  logic                                trace_valid_o;
  commit_pkg::trace_out_t              trace_o;
  logic                                trace_credit_i;
  logic                                trap_valid_o;
  commit_pkg::trap_rec_t               trap_o;
  logic                                trap_credit_i;
  commit_pkg::perf_addr_t              perf_addr_i;
  logic [commit_pkg::CNT_W-1:0]        perf_data_o;

  int seed = 32'he901de69;
  int errors = 0;
  int tests_failed = 0;
  int cycle_cnt = 0;
  int trace_seen = 0;
  int tr_pending = 0;
  int tp_pending = 0;
  bit hold_credits = 1'b0;

  // Expected words, one queue per commit port
  commit_pkg::trace_out_t exp_trace_q [NP][$];
  commit_pkg::trap_rec_t  exp_trap_q [$];
  int exp_retired = 0;
  int exp_exc = 0;
  int exp_irq = 0;

  commit_trace_top i_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  always @(posedge clk_i) if (rst_ni) cycle_cnt++;

  initial begin
    repeat (WD_CYCLES) @(posedge clk_i);
    $display("Timeout: run did not finish within %0d cycles", WD_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  // --------------------------------------------------------------------
  // Reference model
  // --------------------------------------------------------------------
  function automatic int model_commit(input commit_pkg::commit_entry_t [NP-1:0] ent,
                                      input logic [NP-1:0] ack);
    commit_pkg::trace_out_t w;
    commit_pkg::trap_rec_t  t;
    bit                     trap_taken;
    int                     n;
    trap_taken = 1'b0;
    n = 0;
    for (int p = 0; p < NP; p++) begin
      if (ack[p]) begin
        n++;
        if (!ent[p].ex_valid) begin
          w.port = p[commit_pkg::PORT_W-1:0];
          w.pc   = ent[p].pc;
          w.insn = ent[p].insn;
          exp_trace_q[p].push_back(w);
          exp_retired++;
        end else if (!trap_taken) begin
          // Later trapping ports in the same cycle are not recorded
          trap_taken = 1'b1;
          t.pc     = ent[p].pc;
          t.cause  = ent[p].cause;
          t.is_irq = ent[p].cause[commit_pkg::CAUSE_W-1];
          exp_trap_q.push_back(t);
          if (t.is_irq) exp_irq++;
          else exp_exc++;
        end
      end
    end
    return n;
  endfunction

  // --------------------------------------------------------------------
  // Compare tasks
  // --------------------------------------------------------------------
  task automatic check_trace(input commit_pkg::trace_out_t act, input commit_pkg::trace_out_t exp);
    if (act !== exp) begin
      $display("[ERROR] trace_o act=%h exp=%h", act, exp);
      errors++;
    end
  endtask

  task automatic check_trap(input commit_pkg::trap_rec_t act, input commit_pkg::trap_rec_t exp);
    if (act !== exp) begin
      $display("[ERROR] trap_o act=%h exp=%h", act, exp);
      errors++;
    end
  endtask

  task automatic check_count(input string name, input logic [commit_pkg::CNT_W-1:0] act,
                             input logic [commit_pkg::CNT_W-1:0] exp);
    if (act !== exp) begin
      $display("[ERROR] %s act=%h exp=%h", name, act, exp);
      errors++;
    end
  endtask

  // Stream monitor, sampled mid-cycle
  always @(negedge clk_i) begin
    if (rst_ni && trace_valid_o) begin
      trace_seen++;
      tr_pending++;
      if (exp_trace_q[trace_o.port].size() == 0) begin
        $display("Unexpected retirement word from port %0d", trace_o.port);
        errors++;
      end else begin
        check_trace(trace_o, exp_trace_q[trace_o.port].pop_front());
      end
    end
    if (rst_ni && trap_valid_o) begin
      tp_pending++;
      if (exp_trap_q.size() == 0) begin
        $display("Unexpected word on the trap stream");
        errors++;
      end else begin
        check_trap(trap_o, exp_trap_q.pop_front());
      end
    end
  end

  // Credit return after a random delay
  initial begin
    forever begin
      @(posedge clk_i);
      #2;
      trace_credit_i = 1'b0;
      trap_credit_i  = 1'b0;
      if (!hold_credits && tr_pending > 0 && $random(seed) % 2 == 0) begin
        trace_credit_i = 1'b1;
        tr_pending--;
      end
      if (!hold_credits && tp_pending > 0 && $random(seed) % 2 == 0) begin
        trap_credit_i = 1'b1;
        tp_pending--;
      end
    end
  end

  // --------------------------------------------------------------------
  // Stimulus helpers
  // --------------------------------------------------------------------
  task automatic run_commits(input int n, input logic [NP-1:0] port_en, input bit with_traps);
    int                                 left;
    logic [NP-1:0]                      ack;
    commit_pkg::commit_entry_t [NP-1:0] ent;
    left = n;
    while (left > 0) begin
      @(posedge clk_i);
      #2;
      for (int p = 0; p < NP; p++) begin
        ent[p].pc       = {$random(seed), $random(seed)};
        ent[p].insn     = $random(seed);
        ent[p].ex_valid = with_traps && ($random(seed) % 4 == 0);
        ent[p].cause    = {$random(seed), $random(seed)};
      end
      ack = commit_stall_o ? '0 : (port_en & $random(seed));
      commit_i     = ent;
      commit_ack_i = ack;
      left = left - model_commit(ent, ack);
    end
    @(posedge clk_i);
    #2;
    commit_ack_i = '0;
  endtask

  task automatic drain_streams();
    int waited;
    waited = 0;
    while ((exp_trace_q[0].size() + exp_trace_q[1].size() + exp_trap_q.size()
            + tr_pending + tp_pending) != 0 && waited < 400) begin
      @(posedge clk_i);
      waited++;
    end
    if (waited >= 400) begin
      $display("Streams did not drain, words or credits are still outstanding");
      errors++;
    end
    repeat (2) @(posedge clk_i);
  endtask

  task automatic read_counter(input commit_pkg::perf_addr_t a,
                              output logic [commit_pkg::CNT_W-1:0] v);
    @(posedge clk_i);
    #2;
    perf_addr_i = a;
    @(posedge clk_i);
    @(negedge clk_i);
    v = perf_data_o;
  endtask

  task automatic end_test(input int num, input string name, input int err_before);
    if (errors == err_before) begin
      $display("[test %0d] %s: pass", num, name);
    end else begin
      $display("[test %0d] %s: fail with %0d errors", num, name, errors - err_before);
      tests_failed++;
    end
  endtask

  // --------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------
  initial begin
    int                           e0;
    int                           base;
    int                           cycles_run;
    bit                           stalled;
    logic [commit_pkg::CNT_W-1:0] v;
    rst_ni         = 1'b0;
    commit_i       = '0;
    commit_ack_i   = '0;
    trace_credit_i = 1'b0;
    trap_credit_i  = 1'b0;
    perf_addr_i    = commit_pkg::PERF_CYCLES;
    repeat (2) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;

    e0 = errors;
    @(negedge clk_i);
    check_count("trace_valid_o", trace_valid_o, 0);
    check_count("trap_valid_o", trap_valid_o, 0);
    check_count("commit_stall_o", commit_stall_o, 0);
    check_count("perf_data_o", perf_data_o, 0);
    read_counter(commit_pkg::PERF_RETIRED, v);
    check_count("perf_retired", v, 0);
    read_counter(commit_pkg::PERF_EXCEPTIONS, v);
    check_count("perf_exceptions", v, 0);
    read_counter(commit_pkg::PERF_INTERRUPTS, v);
    check_count("perf_interrupts", v, 0);
    end_test(1, "reset state", e0);

    e0 = errors;
    run_commits(20, 2'b01, 1'b0);
    drain_streams();
    end_test(2, "single-port retirements", e0);

    e0 = errors;
    run_commits(60, 2'b11, 1'b0);
    drain_streams();
    end_test(3, "both ports, random acknowledges", e0);

    e0 = errors;
    run_commits(30, 2'b11, 1'b1);
    drain_streams();
    end_test(4, "traps", e0);

    e0 = errors;
    hold_credits = 1'b1;
    base = trace_seen;
    fork
      run_commits(24, 2'b11, 1'b0);
      begin
        stalled = 1'b0;
        for (int c = 0; c < 200 && !stalled; c++) begin
          @(negedge clk_i);
          stalled = commit_stall_o;
        end
        if (!stalled) begin
          $display("Stall never rose while credits were withheld");
          errors++;
        end
        repeat (10) @(posedge clk_i);
        if (trace_seen - base > commit_pkg::OUT_CREDITS) begin
          $display("%0d words issued without credit", trace_seen - base);
          errors++;
        end
        hold_credits = 1'b0;
      end
    join
    drain_streams();
    end_test(5, "back-pressure", e0);

    e0 = errors;
    cycles_run = cycle_cnt;
    read_counter(commit_pkg::PERF_RETIRED, v);
    check_count("perf_retired", v, exp_retired);
    read_counter(commit_pkg::PERF_EXCEPTIONS, v);
    check_count("perf_exceptions", v, exp_exc);
    read_counter(commit_pkg::PERF_INTERRUPTS, v);
    check_count("perf_interrupts", v, exp_irq);
    read_counter(commit_pkg::PERF_CYCLES, v);
    if (v < cycles_run) begin
      $display("[ERROR] perf_cycles act=%h min=%h", v, cycles_run);
      errors++;
    end
    end_test(6, "counters", e0);

    errors = errors + i_dut.i_ctrl.i_assert.fail_cnt;
    $display("Summary: 6 tests, %0d failed, %0d errors", tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/commit_trace_assert.sv
// Commit trace protocol assertions
`default_nettype none

module commit_trace_assert (
  input wire logic                                   clk_i,
  input wire logic                                   rst_ni,
  input wire logic [commit_pkg::CRED_W-1:0]          tr_cred_i,
  input wire logic [commit_pkg::CRED_W-1:0]          tp_cred_i,
  input wire logic                                   trace_valid_i,
  input wire logic                                   trap_valid_i,
  input wire logic                                   commit_stall_i,
  input wire logic [commit_pkg::NR_COMMIT_PORTS-1:0] rq_push_i,
  input wire logic [commit_pkg::NR_COMMIT_PORTS-1:0] rq_full_i,
  input wire logic                                   tq_push_i,
  input wire logic                                   tq_full_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // Read by the testbench top for its final verdict
  int fail_cnt = 0;

  // --------------------------------------------------------------------
  // Credits
  // --------------------------------------------------------------------
  a_trace_credit : assert property (@(posedge clk_i) disable iff (!rst_ni)
    trace_valid_i |-> (tr_cred_i != '0))
    else begin
      $error("trace word shown with no credit");
      fail_cnt++;
    end

  a_trap_credit : assert property (@(posedge clk_i) disable iff (!rst_ni)
    trap_valid_i |-> (tp_cred_i != '0))
    else begin
      $error("trap word shown with no credit");
      fail_cnt++;
    end

  a_credit_max : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (tr_cred_i <= commit_pkg::OUT_CREDITS) && (tp_cred_i <= commit_pkg::OUT_CREDITS))
    else begin
      $error("credit counter above its reset value");
      fail_cnt++;
    end

  // --------------------------------------------------------------------
  // Queues and stall
  // --------------------------------------------------------------------
  a_push_full : assert property (@(posedge clk_i) disable iff (!rst_ni)
    ((rq_push_i & rq_full_i) == '0) && !(tq_push_i && tq_full_i))
    else begin
      $error("push into a full queue");
      fail_cnt++;
    end

  // A full queue must already be covered by the registered stall
  a_full_stall : assert property (@(posedge clk_i) disable iff (!rst_ni)
    ((|rq_full_i) || tq_full_i) |-> commit_stall_i)
    else begin
      $error("queue full while commit is not stalled");
      fail_cnt++;
    end

endmodule

bind trace_ctrl commit_trace_assert i_assert (
  .clk_i          ( clk_i          ),
  .rst_ni         ( rst_ni         ),
  .tr_cred_i      ( tr_cred_q      ),
  .tp_cred_i      ( tp_cred_q      ),
  .trace_valid_i  ( trace_valid_o  ),
  .trap_valid_i   ( trap_valid_o   ),
  .commit_stall_i ( commit_stall_o ),
  .rq_push_i      ( rq_push_o      ),
  .rq_full_i      ( rq_full_i      ),
  .tq_push_i      ( tq_push_o      ),
  .tq_full_i      ( tq_full_i      )
);

`default_nettype wire

//--- verilog/commit_trace_top.sv
// Commit trace top level
`default_nettype none

module commit_trace_top (
  input  wire logic                                                 clk_i,
  input  wire logic                                                 rst_ni,
  input  commit_pkg::commit_entry_t [commit_pkg::NR_COMMIT_PORTS-1:0] commit_i,
  input  wire logic [commit_pkg::NR_COMMIT_PORTS-1:0]               commit_ack_i,
  output logic                                                      commit_stall_o,
  output logic                                                      trace_valid_o,
  output commit_pkg::trace_out_t                                    trace_o,
  input  wire logic                                                 trace_credit_i,
  output logic                                                      trap_valid_o,
  output commit_pkg::trap_rec_t                                     trap_o,
  input  wire logic                                                 trap_credit_i,
  input  commit_pkg::perf_addr_t                                    perf_addr_i,
  output logic [commit_pkg::CNT_W-1:0]                              perf_data_o
);

  // --------------------------------------------------------------------
  // Control to queue wiring
  // --------------------------------------------------------------------
  logic [commit_pkg::NR_COMMIT_PORTS-1:0]                    rq_push;
  logic [commit_pkg::NR_COMMIT_PORTS-1:0]                    rq_pop;
  logic [commit_pkg::NR_COMMIT_PORTS-1:0]                    rq_empty;
  logic [commit_pkg::NR_COMMIT_PORTS-1:0]                    rq_full;
  logic [commit_pkg::NR_COMMIT_PORTS-1:0]                    rq_afull;
  commit_pkg::retire_rec_t [commit_pkg::NR_COMMIT_PORTS-1:0] rq_data;
  commit_pkg::retire_rec_t [commit_pkg::NR_COMMIT_PORTS-1:0] rq_head;

  logic                  tq_push;
  logic                  tq_pop;
  logic                  tq_empty;
  logic                  tq_full;
  logic                  tq_afull;
  commit_pkg::trap_rec_t tq_data;
  commit_pkg::trap_rec_t tq_head;

  logic [commit_pkg::NR_COMMIT_PORTS-1:0] arb_req;
  logic                                   arb_advance;
  logic                                   arb_gnt;
  logic [commit_pkg::PORT_W-1:0]          arb_idx;

  logic [commit_pkg::NR_COMMIT_PORTS-1:0] ev_retire;
  logic                                   ev_exc;
  logic                                   ev_irq;

  trace_ctrl i_ctrl (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .commit_i       ( commit_i       ),
    .commit_ack_i   ( commit_ack_i   ),
    .commit_stall_o ( commit_stall_o ),
    .rq_push_o      ( rq_push        ),
    .rq_data_o      ( rq_data        ),
    .rq_pop_o       ( rq_pop         ),
    .rq_empty_i     ( rq_empty       ),
    .rq_full_i      ( rq_full        ),
    .rq_afull_i     ( rq_afull       ),
    .rq_head_i      ( rq_head        ),
    .tq_push_o      ( tq_push        ),
    .tq_data_o      ( tq_data        ),
    .tq_pop_o       ( tq_pop         ),
    .tq_empty_i     ( tq_empty       ),
    .tq_full_i      ( tq_full        ),
    .tq_afull_i     ( tq_afull       ),
    .tq_head_i      ( tq_head        ),
    .arb_req_o      ( arb_req        ),
    .arb_advance_o  ( arb_advance    ),
    .arb_idx_i      ( arb_idx        ),
    .arb_gnt_i      ( arb_gnt        ),
    .ev_retire_o    ( ev_retire      ),
    .ev_exc_o       ( ev_exc         ),
    .ev_irq_o       ( ev_irq         ),
    .trace_valid_o  ( trace_valid_o  ),
    .trace_o        ( trace_o        ),
    .trace_credit_i ( trace_credit_i ),
    .trap_valid_o   ( trap_valid_o   ),
    .trap_o         ( trap_o         ),
    .trap_credit_i  ( trap_credit_i  )
  );

  // One retirement queue per commit port
  for (genvar i = 0; i < commit_pkg::NR_COMMIT_PORTS; i++) begin : gen_retire_q
    rec_fifo #(
      .payload_t ( commit_pkg::retire_rec_t ),
      .DEPTH     ( commit_pkg::QUEUE_DEPTH  )
    ) i_q (
      .clk_i         ( clk_i       ),
      .rst_ni        ( rst_ni      ),
      .push_i        ( rq_push[i]  ),
      .data_i        ( rq_data[i]  ),
      .pop_i         ( rq_pop[i]   ),
      .data_o        ( rq_head[i]  ),
      .empty_o       ( rq_empty[i] ),
      .full_o        ( rq_full[i]  ),
      .almost_full_o ( rq_afull[i] )
    );
  end

  rec_fifo #(
    .payload_t ( commit_pkg::trap_rec_t ),
    .DEPTH     ( commit_pkg::QUEUE_DEPTH )
  ) i_trap_q (
    .clk_i         ( clk_i    ),
    .rst_ni        ( rst_ni   ),
    .push_i        ( tq_push  ),
    .data_i        ( tq_data  ),
    .pop_i         ( tq_pop   ),
    .data_o        ( tq_head  ),
    .empty_o       ( tq_empty ),
    .full_o        ( tq_full  ),
    .almost_full_o ( tq_afull )
  );

  rr_arbiter i_arb (
    .clk_i     ( clk_i       ),
    .rst_ni    ( rst_ni      ),
    .req_i     ( arb_req     ),
    .advance_i ( arb_advance ),
    .gnt_o     ( arb_gnt     ),
    .idx_o     ( arb_idx     )
  );

  perf_counters i_perf (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .ev_retire_i ( ev_retire   ),
    .ev_exc_i    ( ev_exc      ),
    .ev_irq_i    ( ev_irq      ),
    .addr_i      ( perf_addr_i ),
    .data_o      ( perf_data_o )
  );

endmodule

`default_nettype wire

//--- verilog/trace_ctrl.sv
// Commit classification and stream control
`default_nettype none

module trace_ctrl (
  input  wire logic                                                   clk_i,
  input  wire logic                                                   rst_ni,
  input  commit_pkg::commit_entry_t [commit_pkg::NR_COMMIT_PORTS-1:0] commit_i,
  input  wire logic [commit_pkg::NR_COMMIT_PORTS-1:0]                 commit_ack_i,
  output logic                                                        commit_stall_o,
  // Retirement queues
  output logic [commit_pkg::NR_COMMIT_PORTS-1:0]                      rq_push_o,
  output commit_pkg::retire_rec_t [commit_pkg::NR_COMMIT_PORTS-1:0]   rq_data_o,
  output logic [commit_pkg::NR_COMMIT_PORTS-1:0]                      rq_pop_o,
  input  wire logic [commit_pkg::NR_COMMIT_PORTS-1:0]                 rq_empty_i,
  input  wire logic [commit_pkg::NR_COMMIT_PORTS-1:0]                 rq_full_i,
  input  wire logic [commit_pkg::NR_COMMIT_PORTS-1:0]                 rq_afull_i,
  input  commit_pkg::retire_rec_t [commit_pkg::NR_COMMIT_PORTS-1:0]   rq_head_i,
  // Trap queue
  output logic                                                        tq_push_o,
  output commit_pkg::trap_rec_t                                       tq_data_o,
  output logic                                                        tq_pop_o,
  input  wire logic                                                   tq_empty_i,
  input  wire logic                                                   tq_full_i,
  input  wire logic                                                   tq_afull_i,
  input  commit_pkg::trap_rec_t                                       tq_head_i,
  // Arbiter
  output logic [commit_pkg::NR_COMMIT_PORTS-1:0]                      arb_req_o,
  output logic                                                        arb_advance_o,
  input  wire logic [commit_pkg::PORT_W-1:0]                          arb_idx_i,
  input  wire logic                                                   arb_gnt_i,
  // Counter strobes
  output logic [commit_pkg::NR_COMMIT_PORTS-1:0]                      ev_retire_o,
  output logic                                                        ev_exc_o,
  output logic                                                        ev_irq_o,
  // Output streams
  output logic                                                        trace_valid_o,
  output commit_pkg::trace_out_t                                      trace_o,
  input  wire logic                                                   trace_credit_i,
  output logic                                                        trap_valid_o,
  output commit_pkg::trap_rec_t                                       trap_o,
  input  wire logic                                                   trap_credit_i
);

  logic [commit_pkg::CRED_W-1:0] tr_cred_q;
  logic [commit_pkg::CRED_W-1:0] tp_cred_q;
  logic                          tr_issue;
  logic                          tp_issue;

  // --------------------------------------------------------------------
  // Commit classification
  // --------------------------------------------------------------------
  always_comb begin
    logic found;
    found     = 1'b0;
    tq_push_o = 1'b0;
    tq_data_o = '0;
    for (int i = 0; i < commit_pkg::NR_COMMIT_PORTS; i++) begin
      rq_push_o[i]      = commit_ack_i[i] & ~commit_i[i].ex_valid;
      rq_data_o[i].pc   = commit_i[i].pc;
      rq_data_o[i].insn = commit_i[i].insn;
      // Only the lowest trapping port is recorded
      if (!found && commit_ack_i[i] && commit_i[i].ex_valid) begin
        found            = 1'b1;
        tq_push_o        = 1'b1;
        tq_data_o.pc     = commit_i[i].pc;
        tq_data_o.cause  = commit_i[i].cause;
        tq_data_o.is_irq = commit_i[i].cause[commit_pkg::CAUSE_W-1];
      end
    end
  end

  assign ev_retire_o = rq_push_o;
  assign ev_exc_o    = tq_push_o & ~tq_data_o.is_irq;
  assign ev_irq_o    = tq_push_o & tq_data_o.is_irq;

  // --------------------------------------------------------------------
  // Issue decision
  // --------------------------------------------------------------------
  // A credit is spent while its word is on the bus
  assign tr_issue = arb_gnt_i & (trace_valid_o ? (tr_cred_q > 1) : (tr_cred_q != '0));
  assign tp_issue = ~tq_empty_i & (trap_valid_o ? (tp_cred_q > 1) : (tp_cred_q != '0));

  assign arb_req_o     = ~rq_empty_i;
  assign arb_advance_o = tr_issue;
  assign tq_pop_o      = tp_issue;

  always_comb begin
    rq_pop_o            = '0;
    rq_pop_o[arb_idx_i] = tr_issue;
  end

  // --------------------------------------------------------------------
  // Control registers
  // --------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tr_cred_q      <= commit_pkg::OUT_CREDITS[commit_pkg::CRED_W-1:0];
      tp_cred_q      <= commit_pkg::OUT_CREDITS[commit_pkg::CRED_W-1:0];
      trace_valid_o  <= 1'b0;
      trap_valid_o   <= 1'b0;
      commit_stall_o <= 1'b0;
    end else begin
      tr_cred_q      <= tr_cred_q - trace_valid_o + trace_credit_i;
      tp_cred_q      <= tp_cred_q - trap_valid_o + trap_credit_i;
      trace_valid_o  <= tr_issue;
      trap_valid_o   <= tp_issue;
      // High once any queue is down to one free slot
      commit_stall_o <= (|rq_afull_i) | (|rq_full_i) | tq_afull_i | tq_full_i;
    end
  end

  // Output words
  always_ff @(posedge clk_i) begin
    if (tr_issue) begin
      trace_o.port <= arb_idx_i;
      trace_o.pc   <= rq_head_i[arb_idx_i].pc;
      trace_o.insn <= rq_head_i[arb_idx_i].insn;
    end
    if (tp_issue) begin
      trap_o <= tq_head_i;
    end
  end

endmodule

`default_nettype wire

//--- verilog/perf_counters.sv
// Commit event counters
`default_nettype none

module perf_counters (
  input  wire logic                                   clk_i,
  input  wire logic                                   rst_ni,
  input  wire logic [commit_pkg::NR_COMMIT_PORTS-1:0] ev_retire_i,
  input  wire logic                                   ev_exc_i,
  input  wire logic                                   ev_irq_i,
  input  commit_pkg::perf_addr_t                      addr_i,
  output logic [commit_pkg::CNT_W-1:0]                data_o
);

  logic [commit_pkg::CNT_W-1:0] cnt_q [4];
  logic [commit_pkg::CNT_W-1:0] retire_sum;

  // Retirements in this cycle, any number of ports
  always_comb begin
    retire_sum = '0;
    for (int i = 0; i < commit_pkg::NR_COMMIT_PORTS; i++) begin
      retire_sum = retire_sum + ev_retire_i[i];
    end
  end

  // --------------------------------------------------------------------
  // Counters, all wrapping
  // --------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < 4; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      cnt_q[commit_pkg::PERF_CYCLES]  <= cnt_q[commit_pkg::PERF_CYCLES] + 1'b1;
      cnt_q[commit_pkg::PERF_RETIRED] <= cnt_q[commit_pkg::PERF_RETIRED] + retire_sum;
      if (ev_exc_i) begin
        cnt_q[commit_pkg::PERF_EXCEPTIONS] <= cnt_q[commit_pkg::PERF_EXCEPTIONS] + 1'b1;
      end
      if (ev_irq_i) begin
        cnt_q[commit_pkg::PERF_INTERRUPTS] <= cnt_q[commit_pkg::PERF_INTERRUPTS] + 1'b1;
      end
    end
  end

  // Read port, one cycle from address to data
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      data_o <= '0;
    end else begin
      data_o <= cnt_q[addr_i];
    end
  end

endmodule

`default_nettype wire

//--- verilog/rr_arbiter.sv
// Round-robin retirement arbiter
`default_nettype none

module rr_arbiter (
  input  wire logic                                   clk_i,
  input  wire logic                                   rst_ni,
  input  wire logic [commit_pkg::NR_COMMIT_PORTS-1:0] req_i,
  input  wire logic                                   advance_i,
  output logic                                        gnt_o,
  output logic [commit_pkg::PORT_W-1:0]               idx_o
);

  // First port to look at
  logic [commit_pkg::PORT_W-1:0] ptr_q;

  // --------------------------------------------------------------------
  // Grant search from the pointer upwards, wrapping
  // --------------------------------------------------------------------
  always_comb begin
    int cand;
    gnt_o = 1'b0;
    idx_o = '0;
    for (int k = 0; k < commit_pkg::NR_COMMIT_PORTS; k++) begin
      cand = (int'(ptr_q) + k) % commit_pkg::NR_COMMIT_PORTS;
      if (!gnt_o && req_i[cand]) begin
        gnt_o = 1'b1;
        idx_o = cand[commit_pkg::PORT_W-1:0];
      end
    end
  end

  // Served port drops to lowest priority
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ptr_q <= '0;
    end else if (advance_i && gnt_o) begin
      if (int'(idx_o) == commit_pkg::NR_COMMIT_PORTS - 1) begin
        ptr_q <= '0;
      end else begin
        ptr_q <= idx_o + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/rec_fifo.sv
// Record queue
`default_nettype none

module rec_fifo #(
  parameter type         payload_t = logic,
  parameter int unsigned DEPTH     = 4
) (
  input  wire logic clk_i,
  input  wire logic rst_ni,
  input  wire logic push_i,
  input  payload_t  data_i,
  input  wire logic pop_i,
  output payload_t  data_o,
  output logic      empty_o,
  output logic      full_o,
  output logic      almost_full_o
);

  payload_t                     mem_q [DEPTH];
  logic [$clog2(DEPTH)-1:0]     wr_ptr_q;
  logic [$clog2(DEPTH)-1:0]     rd_ptr_q;
  logic [$clog2(DEPTH+1)-1:0]   count_q;
  logic                         do_push;
  logic                         do_pop;

  assign empty_o       = (count_q == '0);
  assign full_o        = (int'(count_q) == DEPTH);
  assign almost_full_o = (int'(count_q) == DEPTH - 1);

  // Overflow and underflow requests are dropped
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  // Head is read straight from storage
  assign data_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (int'(wr_ptr_q) == DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (int'(rd_ptr_q) == DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + do_push - do_pop;
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire

//--- verilog/commit_pkg.sv
// Commit trace shared types
`default_nettype none

package commit_pkg;

  // --------------------------------------------------------------------
  // Sizes
  // --------------------------------------------------------------------
  localparam int NR_COMMIT_PORTS = 2;
  localparam int VLEN            = 64;
  localparam int INSN_W          = 32;
  // Top bit of the cause marks an interrupt
  localparam int CAUSE_W         = 64;
  localparam int QUEUE_DEPTH     = 4;
  localparam int OUT_CREDITS     = 4;
  localparam int PORT_W          = (NR_COMMIT_PORTS > 1) ? $clog2(NR_COMMIT_PORTS) : 1;
  localparam int CNT_W           = 32;
  // Credit counter must hold the full reset value
  localparam int CRED_W          = $clog2(OUT_CREDITS + 1);

  // --------------------------------------------------------------------
  // Counter addresses
  // --------------------------------------------------------------------
  typedef logic [1:0] perf_addr_t;

  localparam perf_addr_t PERF_CYCLES     = 2'd0;
  localparam perf_addr_t PERF_RETIRED    = 2'd1;
  localparam perf_addr_t PERF_EXCEPTIONS = 2'd2;
  localparam perf_addr_t PERF_INTERRUPTS = 2'd3;

  // --------------------------------------------------------------------
  // Records
  // --------------------------------------------------------------------
  // One commit slot as seen from the scoreboard
  typedef struct packed {
    logic [VLEN-1:0]    pc;
    logic [INSN_W-1:0]  insn;
    logic               ex_valid;
    logic [CAUSE_W-1:0] cause;
  } commit_entry_t;

  typedef struct packed {
    logic [VLEN-1:0]   pc;
    logic [INSN_W-1:0] insn;
  } retire_rec_t;

  typedef struct packed {
    logic [VLEN-1:0]    pc;
    logic [CAUSE_W-1:0] cause;
    logic               is_irq;
  } trap_rec_t;

  // Retirement stream word, tagged with its source port
  typedef struct packed {
    logic [PORT_W-1:0] port;
    logic [VLEN-1:0]   pc;
    logic [INSN_W-1:0] insn;
  } trace_out_t;

endpackage

`default_nettype wire
